// ==== src/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  localparam int xlen = 32;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // RV32 encodings for the supported subset
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl     = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;
  localparam logic [2:0] f3_word    = 3'b010;  // LW and SW
  localparam logic [2:0] f3_divu    = 3'b101;
  localparam logic [2:0] f3_remu    = 3'b111;

  localparam logic [6:0] f7_base    = 7'b0000000;
  localparam logic [6:0] f7_alt     = 7'b0100000;  // SUB
  localparam logic [6:0] f7_muldiv  = 7'b0000001;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction word views
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef union packed {
    r_fmt_t r_view;
    i_fmt_t i_view;
  } instr_word_t;

  typedef enum logic [2:0] {
    kind_nop, kind_alu, kind_lui, kind_load, kind_store, kind_div, kind_rem
  } op_kind_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_sll, alu_srl
  } alu_op_t;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stage payloads
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  typedef struct packed {
    logic            valid;
    op_kind_t        op_kind;
    alu_op_t         alu_op;
    logic            use_imm;
    logic [4:0]      rd;
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] store_data;
  } decode_out_t;

  typedef struct packed {
    logic            valid;
    logic            wren;
    logic [4:0]      rd;
    logic [xlen-1:0] wdata;
  } exec_out_t;

  typedef struct packed {
    logic            wren;
    logic [4:0]      waddr;
    logic [xlen-1:0] wdata;
  } reg_write_t;

endpackage

`default_nettype wire

// ==== src/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [4:0]                 raddr1,
  input  logic [4:0]                 raddr2,
  output logic [exec_pkg::xlen-1:0]  rdata1,
  output logic [exec_pkg::xlen-1:0]  rdata2,
  input  exec_pkg::reg_write_t       wr
);
  import exec_pkg::*;

  logic [xlen-1:0] regs [32];

  assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];  // x0 is hardwired to zero
  assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr.wren && wr.waddr != 5'd0) begin
      regs[wr.waddr] <= wr.wdata;
    end
  end

endmodule

`default_nettype wire

// ==== src/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       instr_valid,
  input  exec_pkg::instr_word_t      instr,
  input  logic                       stall,
  output logic [4:0]                 raddr1,
  output logic [4:0]                 raddr2,
  input  logic [exec_pkg::xlen-1:0]  rdata1,
  input  logic [exec_pkg::xlen-1:0]  rdata2,
  input  exec_pkg::exec_out_t        ex_fwd,
  input  exec_pkg::reg_write_t       wb_fwd,
  output exec_pkg::decode_out_t      dec
);
  import exec_pkg::*;

  instr_word_t     instr_q;
  logic            valid_q;
  logic [6:0]      opcode;
  logic [6:0]      funct7;
  logic [2:0]      funct3;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] s_imm;
  logic [xlen-1:0] u_imm;
  logic [xlen-1:0] opnd1;
  logic [xlen-1:0] opnd2;

  // Execute result is younger than the write-back one, so it is checked first
  function automatic logic [xlen-1:0] pick_operand(input logic [4:0] addr,
                                                   input logic [xlen-1:0] rf_data,
                                                   input exec_out_t ex_r,
                                                   input reg_write_t wb_r);
    logic [xlen-1:0] value;
    value = rf_data;
    if (addr != 5'd0) begin
      if (ex_r.valid && ex_r.wren && ex_r.rd == addr) begin
        value = ex_r.wdata;
      end else if (wb_r.wren && wb_r.waddr == addr) begin
        value = wb_r.wdata;
      end
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst) begin
      valid_q <= 1'b0;
      instr_q <= '0;
    end else if (!stall) begin  // Held while execute is busy
      valid_q <= instr_valid;
      instr_q <= instr;
    end
  end

  assign opcode = instr_q.r_view.opcode;
  assign funct7 = instr_q.r_view.funct7;
  assign funct3 = instr_q.i_view.funct3;
  assign raddr1 = instr_q.i_view.rs1;
  assign raddr2 = instr_q.r_view.rs2;

  assign i_imm = {{(xlen - 12){instr_q.i_view.imm12[11]}}, instr_q.i_view.imm12};
  assign s_imm = {{(xlen - 12){funct7[6]}}, funct7, instr_q.r_view.rd};
  assign u_imm = {instr_q.i_view.imm12, instr_q.i_view.rs1, funct3, 12'b0};

  assign opnd1 = pick_operand(raddr1, rdata1, ex_fwd, wb_fwd);
  assign opnd2 = pick_operand(raddr2, rdata2, ex_fwd, wb_fwd);

  always_comb begin
    dec            = '0;
    dec.valid      = valid_q;
    dec.rd         = instr_q.i_view.rd;
    dec.a          = opnd1;
    dec.b          = opnd2;
    dec.store_data = opnd2;
    dec.imm        = i_imm;
    dec.op_kind    = kind_nop;  // Anything unrecognised falls through as a no-op
    dec.alu_op     = alu_add;
    case (opcode)
      opc_lui: begin
        dec.op_kind = kind_lui;
        dec.imm     = u_imm;
      end
      opc_op_imm: begin
        dec.use_imm = 1'b1;
        dec.op_kind = kind_alu;
        case (funct3)
          f3_add_sub: dec.alu_op = alu_add;
          f3_and:     dec.alu_op = alu_and;
          f3_or:      dec.alu_op = alu_or;
          f3_xor:     dec.alu_op = alu_xor;
          default:    dec.op_kind = kind_nop;
        endcase
      end
      opc_op: begin
        if (funct7 == f7_muldiv) begin
          if (funct3 == f3_divu) begin
            dec.op_kind = kind_div;
          end else if (funct3 == f3_remu) begin
            dec.op_kind = kind_rem;
          end
        end else if (funct7 == f7_alt) begin
          if (funct3 == f3_add_sub) begin
            dec.op_kind = kind_alu;
            dec.alu_op  = alu_sub;
          end
        end else if (funct7 == f7_base) begin
          dec.op_kind = kind_alu;
          case (funct3)
            f3_add_sub: dec.alu_op = alu_add;
            f3_sll:     dec.alu_op = alu_sll;
            f3_slt:     dec.alu_op = alu_slt;
            f3_xor:     dec.alu_op = alu_xor;
            f3_srl:     dec.alu_op = alu_srl;
            f3_or:      dec.alu_op = alu_or;
            default:    dec.alu_op = alu_and;
          endcase
        end
      end
      opc_load: begin
        if (funct3 == f3_word) begin
          dec.op_kind = kind_load;
        end
      end
      opc_store: begin
        if (funct3 == f3_word) begin
          dec.op_kind = kind_store;
          dec.imm     = s_imm;
          dec.rd      = 5'd0;  // Store has no destination, rd bits hold the offset
        end
      end
      default: dec.op_kind = kind_nop;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module divider #(
  parameter int div_cycles = 32
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  logic [exec_pkg::xlen-1:0]  dividend,
  input  logic [exec_pkg::xlen-1:0]  divisor,
  output logic                       busy,
  output logic                       done,
  output logic [exec_pkg::xlen-1:0]  quotient,
  output logic [exec_pkg::xlen-1:0]  remainder
);
  import exec_pkg::*;

  localparam int cnt_w = $clog2(div_cycles + 1);

  logic [cnt_w-1:0] count;
  logic [xlen-1:0]  divisor_q;
  logic [xlen:0]    partial;
  logic [xlen:0]    trial;
  logic             fits;

  // Quotient register starts as the dividend and shifts its bits out at the top
  assign partial = {remainder, quotient[xlen-1]};
  assign trial   = partial - {1'b0, divisor_q};
  assign fits    = partial >= {1'b0, divisor_q};  // A zero divisor always fits

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy      <= 1'b0;
      done      <= 1'b0;
      count     <= '0;
      quotient  <= '0;
      remainder <= '0;
      divisor_q <= '0;
    end else begin
      done <= 1'b0;
      if (start) begin
        busy      <= 1'b1;
        count     <= '0;
        quotient  <= dividend;
        remainder <= '0;
        divisor_q <= divisor;
      end else if (busy) begin
        if (fits) begin
          remainder <= trial[xlen-1:0];
          quotient  <= {quotient[xlen-2:0], 1'b1};
        end else begin
          remainder <= partial[xlen-1:0];
          quotient  <= {quotient[xlen-2:0], 1'b0};
        end
        count <= count + 1'b1;
        if (count == cnt_w'(div_cycles - 1)) begin
          busy <= 1'b0;
          done <= 1'b1;  // Single-cycle pulse with the final result
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage #(
  parameter int div_cycles = 32
) (
  input  logic                         clk,
  input  logic                         rst,
  input  exec_pkg::decode_out_t        dec,
  output exec_pkg::exec_out_t          ex,
  output logic                         stall,
  output logic                         wb_cyc,
  output logic                         wb_stb,
  output logic                         wb_we,
  output logic [exec_pkg::xlen-1:0]    wb_adr,
  output logic [exec_pkg::xlen-1:0]    wb_dat_w,
  output logic [exec_pkg::xlen/8-1:0]  wb_sel,
  input  logic [exec_pkg::xlen-1:0]    wb_dat_r,
  input  logic                         wb_ack
);
  import exec_pkg::*;

  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] mem_addr;
  logic [xlen-1:0] quotient;
  logic [xlen-1:0] remainder;
  logic            is_div;
  logic            is_mem;
  logic            div_start;
  logic            div_busy;
  logic            div_done;
  logic            bus_done;
  logic            writes;
  exec_out_t       ex_next;

  assign op_b     = dec.use_imm ? dec.imm : dec.b;
  assign mem_addr = dec.a + dec.imm;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // ALU
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    case (dec.alu_op)
      alu_sub: alu_res = dec.a - op_b;
      alu_and: alu_res = dec.a & op_b;
      alu_or:  alu_res = dec.a | op_b;
      alu_xor: alu_res = dec.a ^ op_b;
      alu_slt: alu_res = {{(xlen - 1){1'b0}}, $signed(dec.a) < $signed(op_b)};
      alu_sll: alu_res = dec.a << op_b[4:0];
      alu_srl: alu_res = dec.a >> op_b[4:0];
      default: alu_res = dec.a + op_b;
    endcase
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Multi-cycle control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  assign is_div    = dec.valid && (dec.op_kind == kind_div || dec.op_kind == kind_rem);
  assign is_mem    = dec.valid && (dec.op_kind == kind_load || dec.op_kind == kind_store);
  assign bus_done  = wb_cyc && wb_ack;
  assign div_start = is_div && !div_busy && !div_done;  // One launch per divide
  assign stall     = (is_div && !div_done) || (is_mem && !bus_done);

  divider #(
    .div_cycles (div_cycles)
  ) u_divider (
    .clk       (clk),
    .rst       (rst),
    .start     (div_start),
    .dividend  (dec.a),
    .divisor   (dec.b),
    .busy      (div_busy),
    .done      (div_done),
    .quotient  (quotient),
    .remainder (remainder)
  );

  always_ff @(posedge clk) begin
    if (!rst) begin
      wb_cyc   <= 1'b0;
      wb_stb   <= 1'b0;
      wb_we    <= 1'b0;
      wb_adr   <= '0;
      wb_dat_w <= '0;
    end else if (bus_done) begin
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
    end else if (is_mem && !wb_cyc) begin
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= dec.op_kind == kind_store;
      wb_adr   <= mem_addr;
      wb_dat_w <= dec.store_data;
    end
  end

  assign wb_sel = '1;  // Word accesses only

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Result select and execute register
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    writes        = 1'b1;
    ex_next.valid = dec.valid;
    ex_next.rd    = dec.rd;
    case (dec.op_kind)
      kind_alu:  ex_next.wdata = alu_res;
      kind_lui:  ex_next.wdata = dec.imm;
      kind_load: ex_next.wdata = wb_dat_r;
      kind_div:  ex_next.wdata = quotient;
      kind_rem:  ex_next.wdata = remainder;
      default: begin
        ex_next.wdata = alu_res;
        writes        = 1'b0;
      end
    endcase
    ex_next.wren = dec.valid && writes && dec.rd != 5'd0;
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ex <= '0;
    end else if (stall) begin
      ex.valid <= 1'b0;  // Bubble towards write-back
      ex.wren  <= 1'b0;
    end else begin
      ex <= ex_next;
    end
  end

endmodule

`default_nettype wire

// ==== src/result_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  exec_pkg::exec_out_t        ex,
  output exec_pkg::reg_write_t       wr,
  output logic                       retire_valid,
  output logic [4:0]                 retire_rd,
  output logic [exec_pkg::xlen-1:0]  retire_data
);

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr <= '0;
    end else begin
      wr.wren  <= ex.valid && ex.wren;  // Stores, no-ops and x0 writes drop out here
      wr.waddr <= ex.rd;
      wr.wdata <= ex.wdata;
    end
  end

  // The retire port shows exactly what the register file is about to take
  assign retire_valid = wr.wren;
  assign retire_rd    = wr.waddr;
  assign retire_data  = wr.wdata;

endmodule

`default_nettype wire

// ==== src/exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
  parameter int data_width = exec_pkg::xlen,
  parameter int div_cycles = 32
) (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     instr_valid,
  input  exec_pkg::instr_word_t    instr,
  output logic                     instr_ready,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output logic [data_width-1:0]    wb_adr,
  output logic [data_width-1:0]    wb_dat_w,
  output logic [data_width/8-1:0]  wb_sel,
  input  logic [data_width-1:0]    wb_dat_r,
  input  logic                     wb_ack,
  output logic                     retire_valid,
  output logic [4:0]               retire_rd,
  output logic [data_width-1:0]    retire_data
);
  import exec_pkg::*;

  decode_out_t     dec;
  exec_out_t       ex;
  reg_write_t      wr;
  logic [4:0]      raddr1;
  logic [4:0]      raddr2;
  logic [xlen-1:0] rdata1;
  logic [xlen-1:0] rdata2;
  logic            stall;

  assign instr_ready = ~stall;

  decode_stage u_decode (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .stall       (stall),
    .raddr1      (raddr1),
    .raddr2      (raddr2),
    .rdata1      (rdata1),
    .rdata2      (rdata2),
    .ex_fwd      (ex),
    .wb_fwd      (wr),
    .dec         (dec)
  );

  register_file u_regs (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (raddr1),
    .raddr2 (raddr2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .wr     (wr)
  );

  execute_stage #(
    .div_cycles (div_cycles)
  ) u_execute (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .ex       (ex),
    .stall    (stall),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_sel   (wb_sel),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  result_stage u_result (
    .clk          (clk),
    .rst          (rst),
    .ex           (ex),
    .wr           (wr),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

endmodule

`default_nettype wire

// ==== bench/result_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_checker (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         retire_valid,
  input  logic [4:0]                   retire_rd,
  input  logic [exec_pkg::xlen-1:0]    retire_data,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic [exec_pkg::xlen/8-1:0]  wb_sel
);
  import exec_pkg::*;

  string           name_q [$];
  logic [4:0]      rd_q   [$];
  logic [xlen-1:0] data_q [$];
  int              pass_count = 0;
  int              fail_count = 0;

  task automatic expect_entry(input string name, input logic [4:0] rd,
                              input logic [xlen-1:0] data);
    name_q.push_back(name);
    rd_q.push_back(rd);
    data_q.push_back(data);
  endtask

  function automatic int pending_count();
    return name_q.size();
  endfunction

  // Retire outputs come from a register, so the edge sees a settled value
  always @(posedge clk) begin
    string           name;
    logic [4:0]      rd;
    logic [xlen-1:0] data;
    if (rst && wb_cyc && wb_stb && wb_sel != 4'hf) begin  // Word accesses use all bytes
      fail_count++;
      $display("mismatch wb_sel: expected %h, actual %h", 4'hf, wb_sel);
    end
    if (rst && retire_valid) begin
      if (name_q.size() == 0) begin
        fail_count++;
        $display("unexpected retire of x%0d = %08h when no result was due",
                 retire_rd, retire_data);
      end else begin
        name = name_q.pop_front();
        rd   = rd_q.pop_front();
        data = data_q.pop_front();
        if (retire_rd == rd && retire_data == data) begin
          pass_count++;
          $display("pass %s: x%0d = %08h", name, rd, data);
        end else begin
          fail_count++;
          $display("mismatch %s: expected x%0d = %08h, actual x%0d = %08h",
                   name, rd, data, retire_rd, retire_data);
        end
      end
    end
  end

  task automatic close_report();
    while (name_q.size() != 0) begin
      fail_count++;
      $display("test %s never retired its write to x%0d", name_q[0], rd_q[0]);
      void'(name_q.pop_front());
      void'(rd_q.pop_front());
      void'(data_q.pop_front());
    end
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
  endtask

endmodule

`default_nettype wire

// ==== bench/tb_exec_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;
  import exec_pkg::*;

  localparam int data_width = 32;
  localparam int div_cycles = 32;
  localparam int max_rows   = 64;

  logic                    clk = 1'b0;
  logic                    rst;
  logic                    instr_valid;
  instr_word_t             instr;
  logic                    instr_ready;
  logic                    wb_cyc;
  logic                    wb_stb;
  logic                    wb_we;
  logic [data_width-1:0]   wb_adr;
  logic [data_width-1:0]   wb_dat_w;
  logic [data_width/8-1:0] wb_sel;
  logic [data_width-1:0]   wb_dat_r;
  logic                    wb_ack;
  logic                    retire_valid;
  logic [4:0]              retire_rd;
  logic [data_width-1:0]   retire_data;

  string       row_name    [max_rows];
  logic [31:0] row_word    [max_rows];
  logic [4:0]  row_rd      [max_rows];
  logic [31:0] row_value   [max_rows];
  logic        row_retires [max_rows];
  int          n_rows;
  int          n_expected;

  logic [31:0] model_regs [32];
  logic [31:0] model_mem  [64];
  logic [31:0] mem        [64];
  integer      seed;
  int          timeout_limit;
  int          cycle_count = 0;

  always #20 clk = ~clk;

  exec_core #(
    .data_width (data_width),
    .div_cycles (div_cycles)
  ) u_dut (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_sel       (wb_sel),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  result_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_sel       (wb_sel)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Instruction encoders and RV32 reference rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, opc_op};
  endfunction

  function automatic logic [31:0] i_type_word(input logic [6:0] opc, input logic [2:0] f3,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type_word(input logic [4:0] rs2, input logic [4:0] rs1,
                                              input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3_word, imm[4:0], opc_store};
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return 32'h5a5a_0000 ^ (idx * 32'h9e37_79b1);  // Every address bit shows up
  endfunction

  function automatic logic [31:0] reg_reg_result(input logic [6:0] f7, input logic [2:0] f3,
                                                 input logic [31:0] a, input logic [31:0] b);
    if (f7 == f7_muldiv) begin
      if (f3 == f3_divu) begin
        return (b == 32'd0) ? 32'hffff_ffff : a / b;
      end
      return (b == 32'd0) ? a : a % b;
    end
    case (f3)
      f3_add_sub: return (f7 == f7_alt) ? a - b : a + b;
      f3_sll:     return a << b[4:0];
      f3_slt:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      f3_xor:     return a ^ b;
      f3_srl:     return a >> b[4:0];
      f3_or:      return a | b;
      default:    return a & b;
    endcase
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus table with a register and memory model
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  task automatic append_row(input string name, input logic [31:0] word, input int rd,
                            input logic [31:0] value, input logic retires);
    row_name[n_rows]    = name;
    row_word[n_rows]    = word;
    row_rd[n_rows]      = 5'(rd);
    row_value[n_rows]   = value;
    row_retires[n_rows] = retires;
    if (retires) begin
      model_regs[rd] = value;
      n_expected++;
    end
    n_rows++;
  endtask

  task automatic lui_case(input string name, input int rd, input logic [19:0] upper);
    append_row(name, {upper, 5'(rd), opc_lui}, rd, {upper, 12'b0}, rd != 0);
  endtask

  task automatic imm_case(input string name, input logic [2:0] f3, input int rd,
                          input int rs1, input logic [11:0] imm);
    logic [31:0] a;
    logic [31:0] simm;
    logic [31:0] value;
    a    = model_regs[rs1];
    simm = {{20{imm[11]}}, imm};
    case (f3)
      f3_and:  value = a & simm;
      f3_or:   value = a | simm;
      f3_xor:  value = a ^ simm;
      default: value = a + simm;
    endcase
    append_row(name, i_type_word(opc_op_imm, f3, 5'(rd), 5'(rs1), imm), rd, value, rd != 0);
  endtask

  task automatic reg_case(input string name, input logic [6:0] f7, input logic [2:0] f3,
                          input int rd, input int rs1, input int rs2);
    logic [31:0] value;
    value = reg_reg_result(f7, f3, model_regs[rs1], model_regs[rs2]);
    append_row(name, r_type_word(f7, f3, 5'(rd), 5'(rs1), 5'(rs2)), rd, value, rd != 0);
  endtask

  task automatic store_case(input string name, input int rs2, input int rs1,
                            input logic [11:0] imm);
    logic [31:0] addr;
    addr = model_regs[rs1] + {{20{imm[11]}}, imm};
    model_mem[addr[7:2]] = model_regs[rs2];
    append_row(name, s_type_word(5'(rs2), 5'(rs1), imm), 0, 32'd0, 1'b0);
  endtask

  task automatic load_case(input string name, input int rd, input int rs1,
                           input logic [11:0] imm);
    logic [31:0] addr;
    addr = model_regs[rs1] + {{20{imm[11]}}, imm};
    append_row(name, i_type_word(opc_load, f3_word, 5'(rd), 5'(rs1), imm), rd,
               model_mem[addr[7:2]], rd != 0);
  endtask

  // LUI then ADDI, with the upper part rounded for a negative low half
  task automatic set_register(input string name, input int rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    lui_case({name, "_lui"}, rd, upper[31:12]);
    imm_case({name, "_addi"}, f3_add_sub, rd, rd, value[11:0]);
  endtask

  task automatic build_table();
    logic [31:0] rnd_a;
    logic [31:0] rnd_b;
    n_rows     = 0;
    n_expected = 0;
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = 32'd0;
    end
    for (int i = 0; i < 64; i++) begin
      model_mem[i] = fill_word(i);
    end
    rnd_a = $random(seed);
    rnd_b = $random(seed);

    lui_case("lui", 1, 20'h12345);
    imm_case("addi_pos", f3_add_sub, 2, 1, 12'h678);
    imm_case("addi_neg", f3_add_sub, 3, 2, 12'hfff);
    imm_case("andi_neg", f3_and, 4, 2, 12'hff0);
    imm_case("ori_neg", f3_or, 5, 0, 12'h800);
    imm_case("xori_neg", f3_xor, 6, 2, 12'hfff);
    imm_case("xori_pos", f3_xor, 6, 6, 12'h0f0);
    imm_case("addi_small", f3_add_sub, 7, 0, 12'd100);

    set_register("opnd_a", 8, rnd_a);
    set_register("opnd_b", 9, rnd_b);
    reg_case("add", f7_base, f3_add_sub, 10, 8, 9);
    reg_case("sub", f7_alt, f3_add_sub, 11, 8, 9);
    reg_case("and", f7_base, f3_and, 12, 8, 9);
    reg_case("or", f7_base, f3_or, 13, 8, 9);
    reg_case("xor", f7_base, f3_xor, 14, 8, 9);
    reg_case("slt_ab", f7_base, f3_slt, 15, 8, 9);
    reg_case("slt_ba", f7_base, f3_slt, 16, 9, 8);
    reg_case("sll", f7_base, f3_sll, 17, 8, 9);
    reg_case("srl", f7_base, f3_srl, 18, 8, 9);
    reg_case("fwd_two_back", f7_base, f3_add_sub, 19, 17, 10);
    reg_case("fwd_one_back", f7_base, f3_add_sub, 20, 19, 19);
    reg_case("fwd_sub_chain", f7_alt, f3_add_sub, 21, 20, 8);
    reg_case("fwd_mixed", f7_base, f3_xor, 22, 21, 19);

    reg_case("divu", f7_muldiv, f3_divu, 23, 8, 9);
    reg_case("remu", f7_muldiv, f3_remu, 24, 8, 9);
    reg_case("add_after_rem", f7_base, f3_add_sub, 25, 23, 24);
    reg_case("divu_zero", f7_muldiv, f3_divu, 26, 8, 0);
    reg_case("remu_zero", f7_muldiv, f3_remu, 27, 8, 0);
    imm_case("addi_divisor", f3_add_sub, 28, 0, 12'd7);
    reg_case("divu_small", f7_muldiv, f3_divu, 29, 7, 28);
    reg_case("add_after_div", f7_base, f3_add_sub, 31, 29, 29);
    reg_case("remu_small", f7_muldiv, f3_remu, 30, 7, 28);
    reg_case("sub_after_rem", f7_alt, f3_add_sub, 25, 30, 29);

    imm_case("base_addr", f3_add_sub, 1, 0, 12'h100);
    store_case("sw_a", 8, 1, 12'h000);
    store_case("sw_b", 9, 1, 12'h004);
    load_case("lw_a", 2, 1, 12'h000);
    load_case("lw_b", 3, 1, 12'h004);
    reg_case("add_loads", f7_base, f3_add_sub, 4, 2, 3);
    store_case("sw_neg_offset", 4, 1, 12'hffc);
    load_case("lw_neg_offset", 5, 1, 12'hffc);
    load_case("lw_a_again", 6, 1, 12'h000);

    reg_case("add_to_x0", f7_base, f3_add_sub, 0, 8, 9);
    imm_case("addi_to_x0", f3_add_sub, 0, 0, 12'h5a5);
    reg_case("read_x0", f7_base, f3_or, 7, 0, 0);
    imm_case("addi_from_x0", f3_add_sub, 10, 0, 12'h123);
    append_row("illegal_nop", 32'hffff_ffff, 0, 32'd0, 1'b0);
    reg_case("x31_kept", f7_base, f3_or, 11, 31, 0);
  endtask

  // Called a little after a rising edge, returns at the same point after the transfer
  task automatic issue_instr(input logic [31:0] word);
    logic taken;
    instr_valid = 1'b1;
    instr       = word;
    taken       = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = instr_ready;
      @(posedge clk);
      #2;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Wishbone memory slave with a random ack delay of 1 to 3 cycles
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  initial begin
    logic        pending;
    int          ack_wait;
    int          idx;
    logic [31:0] rnd;
    wb_ack   = 1'b0;
    wb_dat_r = '0;
    pending  = 1'b0;
    ack_wait = 0;
    for (int i = 0; i < 64; i++) begin
      mem[i] = fill_word(i);
    end
    forever begin
      @(posedge clk);
      #2;
      if (!rst) begin
        wb_ack  = 1'b0;
        pending = 1'b0;
      end else if (wb_ack) begin
        wb_ack = 1'b0;  // Master drops cyc on the edge that saw ack
      end else if (wb_cyc && wb_stb) begin
        if (!pending) begin
          pending  = 1'b1;
          rnd      = $random(seed);
          ack_wait = int'(rnd % 3);
        end
        if (ack_wait == 0) begin
          idx = int'(wb_adr[7:2]);
          if (wb_we) begin
            mem[idx] = wb_dat_w;
          end else begin
            wb_dat_r = mem[idx];
          end
          wb_ack  = 1'b1;
          pending = 1'b0;
        end else begin
          ack_wait = ack_wait - 1;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (timeout_limit > 0 && cycle_count >= timeout_limit) begin
      $display("timeout: the run did not finish within %0d cycles", timeout_limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int drain_cycles;
    rst           = 1'b0;
    instr_valid   = 1'b0;
    instr         = '0;
    seed          = 32'h8692;
    timeout_limit = 0;
    build_table();
    timeout_limit = n_rows * (div_cycles + 8);

    repeat (8) @(posedge clk);
    #2;
    rst = 1'b1;

    for (int row = 0; row < n_rows; row++) begin
      if (row_retires[row]) begin
        u_checker.expect_entry(row_name[row], row_rd[row], row_value[row]);
      end
      issue_instr(row_word[row]);
    end
    instr_valid = 1'b0;
    instr       = '0;

    drain_cycles = 0;
    while (u_checker.pending_count() != 0 && drain_cycles < div_cycles + 8) begin
      @(negedge clk);
      drain_cycles++;
    end
    repeat (8) @(negedge clk);  // Room for a stray late retire
    u_checker.close_report();

    if (u_checker.fail_count == 0 && u_checker.pass_count == n_expected) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== files.f ====
src/exec_pkg.sv
src/register_file.sv
src/decode_stage.sv
src/divider.sv
src/execute_stage.sv
src/result_stage.sv
src/exec_core.sv
bench/result_checker.sv
bench/tb_exec_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_exec_core \
  -f files.f -o tb_exec_core
./obj_dir/tb_exec_core > sim.log 2>&1
cat sim.log

if grep -q "Test completed successfully" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
